// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = xbus_rx_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || \
		{ echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/xbus_rx_chk.sv
`timescale 1ns/1ns
`default_nettype none

// Protocol assertions on the phase aligner ports
module xbus_rx_chk (
  input wire logic                          clk_i,
  input wire logic                          rst_i,
  input wire xbus_align_pkg::idly_ctrl_t    idly_i,
  input wire xbus_align_pkg::align_status_t status_i,
  input wire logic                          word_vld_i
);

  // A load and a step in the same cycle leave the tap undefined
  a_ce_ld_apart: assert property (@(posedge clk_i) disable iff (rst_i)
    !(idly_i.ce && idly_i.ld))
    else $error("delay step and load pulsed in the same cycle");

  // Words only leave the aligner once the lane is locked
  a_vld_after_lock: assert property (@(posedge clk_i) disable iff (rst_i)
    word_vld_i |-> status_i.aligned)
    else $error("word strobe seen while the lane is not aligned");

  // A failed training never reports lock as well
  a_error_or_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    !(status_i.error && status_i.aligned))
    else $error("error and aligned are high together");

endmodule

// Attach the checks to every aligner instance
bind xbus_phase_align xbus_rx_chk u_chk (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .idly_i     (idly_o),
  .status_i   (status_o),
  .word_vld_i (word_vld_o)
);

`default_nettype wire

// File: bench/xbus_rx_monitor.sv
`timescale 1ns/1ns
`default_nettype none

// Checker for the receive lane
// Samples the DUT ports on the falling edge, where all of them are stable,
// and compares them with the expectations handed over by the testbench
module xbus_rx_monitor (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_i,
  input  wire logic [xbus_align_pkg::tap_width-1:0] tap_i,
  input  wire xbus_align_pkg::idly_ctrl_t           idly_i,
  input  wire xbus_align_pkg::align_status_t        status_i,
  input  wire xbus_link_pkg::pair_t                 pair_i,
  input  wire logic                                 pair_vld_i,
  input  wire logic [xbus_align_pkg::tap_width-1:0] exp_centre_i,
  input  wire logic [xbus_align_pkg::tap_width-1:0] exp_size_i,
  input  wire logic                                 exp_fail_i,
  input  wire xbus_link_pkg::pair_t                 exp_pair_i,
  input  wire logic                                 exp_push_i,
  output int                                        err_cnt_o,
  output int                                        chk_cnt_o,
  output int                                        pend_cnt_o
);

  int                   err_cnt = 0;
  int                   chk_cnt = 0;
  int                   pend_cnt = 0;
  // Falling edges since reset was released
  int                   cyc = 0;
  logic                 aligned_q = 1'b0;
  logic                 error_q = 1'b0;
  // Pairs still to come, with the cycle of their second data word
  xbus_link_pkg::pair_t exp_q[$];
  int                   exp_cyc_q[$];

  task automatic log_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    err_cnt++;
    $display("error: %s = %h, expected %h (at %0t ns)", name, got, exp, $time);
  endtask

  task automatic report_failure(input string what);
    err_cnt++;
    $display("%s (at %0t ns)", what, $time);
  endtask

  always @(negedge clk_i)
  begin
    xbus_link_pkg::pair_t front;
    int                   front_cyc;
    if (rst_i)
    begin
      cyc       = 0;
      aligned_q = 1'b0;
      error_q   = 1'b0;
      exp_q.delete();
      exp_cyc_q.delete();
    end
    else
    begin
      // ========================================
      // Reset values and the single load pulse
      // ========================================
      if (cyc == 0)
      begin
        chk_cnt++;
        if (idly_i != '0)
          log_mismatch("idly_o", 32'(idly_i), 0);
        if (status_i != '0)
          log_mismatch("status_o", 32'(status_i), 0);
        if (pair_vld_i)
          log_mismatch("pair_vld_o", 32'(pair_vld_i), 0);
      end
      if (cyc == 1)
        chk_cnt++;
      // The load comes in the first cycle after reset and never again
      if (idly_i.ld != (cyc == 1))
        log_mismatch("idly_o.ld", 32'(idly_i.ld), 32'(cyc == 1));

      // ========================================
      // Training result
      // ========================================
      if (status_i.aligned && !aligned_q)
      begin
        chk_cnt++;
        if (exp_fail_i)
          report_failure("lane reported aligned on an eye that cannot be trained");
        else
        begin
          // The delay is parked at the centre when lock is reported
          if (tap_i != exp_centre_i)
            log_mismatch("tap_i", 32'(tap_i), 32'(exp_centre_i));
          if (status_i.eye_size != exp_size_i)
            log_mismatch("status_o.eye_size", 32'(status_i.eye_size), 32'(exp_size_i));
        end
      end
      if (status_i.error && !error_q)
      begin
        chk_cnt++;
        if (!exp_fail_i)
          report_failure("lane reported a training error on a valid eye");
      end
      aligned_q = status_i.aligned;
      error_q   = status_i.error;

      // ========================================
      // Output pairs and their latency
      // ========================================
      if (pair_vld_i)
      begin
        chk_cnt++;
        if (exp_q.size() == 0)
          report_failure("pair strobe seen while no pair was expected");
        else
        begin
          front     = exp_q.pop_front();
          front_cyc = exp_cyc_q.pop_front();
          if (pair_i != front)
            log_mismatch("pair_o", 32'(pair_i), 32'(front));
          // Two cycles from the second data word to the strobe
          if (cyc - front_cyc != 2)
            log_mismatch("pair_vld_o latency", 32'(cyc - front_cyc), 2);
        end
      end
      else if (exp_q.size() > 0 && cyc - exp_cyc_q[0] > 2)
      begin
        report_failure("expected pair strobe never came");
        void'(exp_q.pop_front());
        void'(exp_cyc_q.pop_front());
      end
      if (exp_push_i)
      begin
        exp_q.push_back(exp_pair_i);
        exp_cyc_q.push_back(cyc);
      end
      cyc++;
    end
    pend_cnt = exp_q.size();
  end

  assign err_cnt_o  = err_cnt;
  assign chk_cnt_o  = chk_cnt;
  assign pend_cnt_o = pend_cnt;

endmodule

`default_nettype wire

// File: bench/xbus_rx_tb.sv
`timescale 1ns/1ns
`default_nettype none

// Testbench for the xbus receive lane
// A delay line model sends the training token while its tap lies inside a
// chosen eye window and noise outside it, then random traffic after lock
module xbus_rx_tb;

  localparam int tap_w         = xbus_align_pkg::tap_width;
  localparam int word_w        = xbus_link_pkg::word_width;
  localparam int train_timeout = 4000;
  localparam int drain_timeout = 200;
  localparam int hold_cycles   = 50;
  localparam int num_words     = 40;

  // Expected outcome of one training
  typedef struct packed {
    logic [tap_w-1:0] centre;
    logic [tap_w-1:0] eye_size;
  } eye_ref_t;

  logic                          clk_i = 1'b0;
  logic                          rst_i = 1'b1;
  logic [word_w-1:0]             dat_i = '0;
  logic [tap_w-1:0]              tap_i = '0;
  xbus_align_pkg::idly_ctrl_t    idly_o;
  xbus_align_pkg::align_status_t status_o;
  xbus_link_pkg::pair_t          pair_o;
  logic                          pair_vld_o;

  // Delay line model
  // An empty window means no token at any tap
  xbus_align_pkg::idly_ctrl_t    ctrl_seen = '0;
  int                            eye_lo = 1;
  int                            eye_hi = 0;
  int                            seed = 33;
  // Traffic after lock and the pairs that it should give
  int                            words_left = 0;
  logic                          have_lo = 1'b0;
  logic [word_w-1:0]             lo_word = '0;
  xbus_link_pkg::pair_t          exp_pair = '0;
  logic                          exp_push = 1'b0;
  logic [tap_w-1:0]              exp_centre = '0;
  logic [tap_w-1:0]              exp_size = '0;
  logic                          exp_fail = 1'b0;
  int                            bench_errors = 0;
  int                            mon_errors;
  int                            mon_checks;
  int                            mon_pending;

  xbus_rx_channel #(
    .p_token_run      (3),
    .p_settle_cycles  (8),
    .p_search_timeout (64)
  ) UUT (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .dat_i      (dat_i),
    .tap_i      (tap_i),
    .idly_o     (idly_o),
    .status_o   (status_o),
    .pair_o     (pair_o),
    .pair_vld_o (pair_vld_o)
  );

  xbus_rx_monitor u_monitor (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .tap_i        (tap_i),
    .idly_i       (idly_o),
    .status_i     (status_o),
    .pair_i       (pair_o),
    .pair_vld_i   (pair_vld_o),
    .exp_centre_i (exp_centre),
    .exp_size_i   (exp_size),
    .exp_fail_i   (exp_fail),
    .exp_pair_i   (exp_pair),
    .exp_push_i   (exp_push),
    .err_cnt_o    (mon_errors),
    .chk_cnt_o    (mon_checks),
    .pend_cnt_o   (mon_pending)
  );

  initial
  begin
    forever #10 clk_i = ~clk_i;
  end

  // ========================================
  // Reference model
  // ========================================

  // Every pass finds the true edges, so the sums are num_passes times each
  function automatic eye_ref_t predict_eye(input int lo, input int hi);
    int       sum_end;
    int       sum_start;
    eye_ref_t res;
    sum_end      = xbus_align_pkg::num_passes * hi;
    sum_start    = xbus_align_pkg::num_passes * lo;
    res.centre   = tap_w'((sum_end + sum_start) / (2 * xbus_align_pkg::num_passes));
    res.eye_size = tap_w'((sum_end - sum_start) / xbus_align_pkg::num_passes + 1);
    return res;
  endfunction

  // First data word of a pair goes low, the second high
  function automatic xbus_link_pkg::pair_t join_pair(input logic [word_w-1:0] first,
                                                      input logic [word_w-1:0] second);
    xbus_link_pkg::pair_t p;
    p.lo = first;
    p.hi = second;
    return p;
  endfunction

  function automatic logic in_eye(input logic [tap_w-1:0] tap);
    return (int'(tap) >= eye_lo) && (int'(tap) <= eye_hi);
  endfunction

  // Random data word that never equals the token
  function automatic logic [word_w-1:0] random_data();
    logic [word_w-1:0] w;
    w = word_w'($random(seed));
    while (w == xbus_link_pkg::ctrl_token)
      w = word_w'($random(seed));
    return w;
  endfunction

  // Token corrupted by a sampling phase outside the eye
  function automatic logic [word_w-1:0] corrupt_token();
    logic [word_w-1:0] flip;
    flip = word_w'($random(seed));
    while (flip == '0)
      flip = word_w'($random(seed));
    return xbus_link_pkg::ctrl_token ^ flip;
  endfunction

  // ========================================
  // Delay line model and stimulus
  // ========================================

  always @(posedge clk_i)
  begin
    #2;
    exp_push = 1'b0;
    // The element acts on the control it saw one clock earlier
    if (ctrl_seen.ld)
      tap_i = '0;
    else if (ctrl_seen.ce && ctrl_seen.inc)
      tap_i = tap_i + 1'b1;
    else if (ctrl_seen.ce)
      tap_i = tap_i - 1'b1;
    ctrl_seen = idly_o;
    if (status_o.aligned && words_left > 0)
    begin
      // About one word in four is a token that the packer has to drop
      words_left = words_left - 1;
      if (($random(seed) & 3) == 0)
        dat_i = xbus_link_pkg::ctrl_token;
      else
      begin
        dat_i = random_data();
        if (have_lo)
        begin
          exp_pair = join_pair(lo_word, dat_i);
          exp_push = 1'b1;
          have_lo  = 1'b0;
        end
        else
        begin
          lo_word = dat_i;
          have_lo = 1'b1;
        end
      end
    end
    else if (in_eye(tap_i))
      dat_i = xbus_link_pkg::ctrl_token;
    else
      dat_i = corrupt_token();
  end

  // ========================================
  // Test sequence
  // ========================================

  task automatic wait_sample();
    @(posedge clk_i);
    #5;
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    #2;
    rst_i = 1'b1;
    repeat (4) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
  endtask

  // Trains on one eye window, then sends traffic if lock is expected
  task automatic run_eye(input int lo, input int hi, input logic fail);
    eye_ref_t ref_res;
    int       n;
    ref_res    = predict_eye(lo, hi);
    eye_lo     = lo;
    eye_hi     = hi;
    exp_centre = ref_res.centre;
    exp_size   = ref_res.eye_size;
    exp_fail   = fail;
    have_lo    = 1'b0;
    words_left = 0;
    apply_reset();
    if (!fail)
      words_left = num_words;
    n = 0;
    while (!status_o.aligned && !status_o.error && n < train_timeout)
    begin
      wait_sample();
      n++;
    end
    if (n >= train_timeout)
    begin
      bench_errors++;
      $display("training on eye %0d to %0d did not finish in time", lo, hi);
    end
    else if (!fail && status_o.aligned)
    begin
      // All traffic sent and every expected pair, the last one included, seen
      n = 0;
      while ((words_left > 0 || exp_push || mon_pending > 0) && n < drain_timeout)
      begin
        wait_sample();
        n++;
      end
      if (n >= drain_timeout)
      begin
        bench_errors++;
        $display("traffic on eye %0d to %0d did not drain in time", lo, hi);
      end
    end
    else
    begin
      // The aligner holds in error, the monitor flags any late lock
      for (n = 0; n < hold_cycles; n++)
        wait_sample();
    end
  endtask

  initial
  begin
    int total;
    run_eye(9, 20, 1'b0);
    // Eye reaching the end of the delay line
    run_eye(25, 31, 1'b1);
    // Starts from tap 31 outside the eye, search steps up from 0
    run_eye(3, 26, 1'b0);
    // No token at any tap
    run_eye(1, 0, 1'b1);
    total = bench_errors + mon_errors;
    $display("errors: %0d (monitor %0d, bench %0d), checks: %0d",
             total, mon_errors, bench_errors, mon_checks);
    if (total == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hw/xbus_link_pkg.sv
hw/xbus_align_pkg.sv
hw/xbus_phase_align.sv
hw/xbus_word_pack.sv
hw/xbus_rx_channel.sv
bench/xbus_rx_chk.sv
bench/xbus_rx_monitor.sv
bench/xbus_rx_tb.sv

// File: hw/xbus_align_pkg.sv
`default_nettype none

// ========================================
// Delay control and training definitions
// ========================================

package xbus_align_pkg;

  // Tap counter of the input delay element, taps 0 to 31
  localparam int tap_width = 5;
  localparam logic [tap_width-1:0] tap_max = '1;

  // Number of eye measurements that are averaged
  localparam int num_passes = 4;

  // Shift that divides a sum of num_passes taps back to one tap
  localparam int avg_shift = $clog2(num_passes);

  // Wide enough to hold num_passes taps added together
  localparam int sum_width = tap_width + avg_shift;

  // Cycles between two tap steps while walking to the eye centre
  localparam int walk_gap = 3;

  // Controls of the delay element, all one cycle wide
  // ld returns the tap to 0, ce with inc steps it by +1 or -1
  typedef struct packed {
    logic ce;
    logic inc;
    logic ld;
  } idly_ctrl_t;

  // Training result reported to the outside
  typedef struct packed {
    logic                 aligned;
    logic                 error;
    logic [tap_width-1:0] eye_size;
  } align_status_t;

endpackage

`default_nettype wire

// File: hw/xbus_link_pkg.sv
`default_nettype none

// ========================================
// Link-level definitions of the xbus lane
// ========================================

package xbus_link_pkg;

  // Width of one parallel word as delivered by the deserializer
  localparam int word_width = 14;

  // Control token sent by the far end while the lane trains
  // Its alternating tail gives many transitions, so a bad sampling phase
  // corrupts it quickly
  localparam logic [word_width-1:0] ctrl_token = 14'b11010101010100;

  // One received word after lock
  // The token flag is resolved once in the aligner and carried along
  typedef struct packed {
    logic [word_width-1:0] data;
    logic                  is_token;
  } rx_word_t;

  // Two data words joined into one wide output word
  // The first word of a pair lands in lo, the second in hi
  typedef struct packed {
    logic [word_width-1:0] hi;
    logic [word_width-1:0] lo;
  } pair_t;

endpackage

`default_nettype wire

// File: hw/xbus_phase_align.sv
`timescale 1ns/1ns
`default_nettype none

// Phase aligner for one xbus lane
// Trains the input delay on the control token, parks it at the eye centre
// and then forwards every received word with its token flag
module xbus_phase_align #(
  parameter int p_token_run      = 3,
  parameter int p_settle_cycles  = 8,
  parameter int p_search_timeout = 64
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_i,
  input  wire logic [xbus_link_pkg::word_width-1:0] dat_i,
  input  wire logic [xbus_align_pkg::tap_width-1:0] tap_i,
  output xbus_align_pkg::idly_ctrl_t                idly_o,
  output xbus_align_pkg::align_status_t             status_o,
  output xbus_link_pkg::rx_word_t                   word_o,
  output logic                                      word_vld_o
);

  // Counter widths follow from the parameters
  localparam int run_w     = $clog2(p_token_run + 1);
  localparam int timeout_w = $clog2(p_search_timeout + 1);
  localparam int settle_w  = $clog2(p_settle_cycles + xbus_align_pkg::walk_gap);
  localparam int pass_w    = $clog2(xbus_align_pkg::num_passes);
  localparam int sum_w     = xbus_align_pkg::sum_width;
  localparam int tap_w     = xbus_align_pkg::tap_width;

  typedef enum logic [3:0] {
    st_init,
    st_search,
    st_up_step,
    st_up_wait,
    st_dn_step,
    st_dn_wait,
    st_calc,
    st_walk,
    st_walk_gap,
    st_done,
    st_error
  } state_t;

  state_t state_q;

  logic                              tok_match;
  logic [run_w-1:0]                  run_q;
  logic                              found;
  logic [timeout_w-1:0]              timeout_q;
  logic                              timeout;
  logic [settle_w-1:0]               settle_q;
  logic                              settle_done;
  logic                              gap_done;
  logic [pass_w-1:0]                 pass_q;
  logic [sum_w-1:0]                  sum_end_q;
  logic [sum_w-1:0]                  sum_start_q;
  logic [sum_w:0]                    eye_total;
  logic [sum_w-1:0]                  eye_diff;
  logic [tap_w-1:0]                  centre_q;
  xbus_align_pkg::idly_ctrl_t        idly_q;
  xbus_align_pkg::align_status_t     status_q;
  xbus_link_pkg::rx_word_t           word_q;
  logic                              word_vld_q;

  // ========================================
  // Token detector and search timeout
  // ========================================

  assign tok_match = (dat_i == xbus_link_pkg::ctrl_token);

  // Run length of consecutive tokens, saturating at the required run
  // A single bad word starts the count again
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      run_q <= '0;
    end
    else if (!tok_match)
    begin
      run_q <= '0;
    end
    else if (run_q != run_w'(p_token_run))
    begin
      run_q <= run_q + 1'b1;
    end
  end

  // The settle wait is longer than the delay element latency plus the run,
  // so at the end of a wait the run only covers words from the new tap
  assign found = (run_q == run_w'(p_token_run));

  // Counts search cycles without the token
  // It restarts on each expiry, which is also when the tap is stepped
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      timeout_q <= '0;
    end
    else if (state_q != st_search || found || timeout)
    begin
      timeout_q <= '0;
    end
    else
    begin
      timeout_q <= timeout_q + 1'b1;
    end
  end

  assign timeout = (timeout_q == timeout_w'(p_search_timeout - 1));

  // ========================================
  // Training state machine
  // ========================================

  // Wait states count from 0, so a wait of N cycles ends on count N-1
  assign settle_done = (settle_q == settle_w'(p_settle_cycles - 1));
  assign gap_done    = (settle_q == settle_w'(xbus_align_pkg::walk_gap - 2));

  // Centre is the mean of all ends and starts, i.e. sum over 2*num_passes
  assign eye_total = {1'b0, sum_end_q} + {1'b0, sum_start_q};
  assign eye_diff  = sum_end_q - sum_start_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q  <= st_init;
      idly_q   <= '0;
      status_q <= '0;
      settle_q <= '0;
      pass_q   <= '0;
    end
    else
    begin
      // Delay controls are single-cycle pulses
      idly_q <= '0;

      case (state_q)
        // Return the delay to tap 0 and clear the edge sums
        st_init:
        begin
          idly_q.ld   <= 1'b1;
          sum_end_q   <= '0;
          sum_start_q <= '0;
          pass_q      <= '0;
          state_q     <= st_search;
        end

        // Step up until the token shows, give up once tap 31 has been tried
        st_search:
        begin
          if (found)
          begin
            state_q <= st_up_step;
          end
          else if (timeout)
          begin
            if (tap_i == xbus_align_pkg::tap_max)
            begin
              status_q.error <= 1'b1;
              state_q        <= st_error;
            end
            else
            begin
              idly_q.ce  <= 1'b1;
              idly_q.inc <= 1'b1;
            end
          end
        end

        // Upper edge of the eye
        st_up_step:
        begin
          idly_q.ce  <= 1'b1;
          idly_q.inc <= 1'b1;
          settle_q   <= '0;
          state_q    <= st_up_wait;
        end

        st_up_wait:
        begin
          settle_q <= settle_q + 1'b1;
          if (settle_done)
          begin
            if (!found)
            begin
              // The tap just left the eye, the last good one is below it
              sum_end_q <= sum_end_q + sum_w'(tap_i) - sum_w'(1);
              state_q   <= st_dn_step;
            end
            else if (tap_i == xbus_align_pkg::tap_max)
            begin
              // Eye reaches the end of the delay line, no edge to find
              status_q.error <= 1'b1;
              state_q        <= st_error;
            end
            else
            begin
              state_q <= st_up_step;
            end
          end
        end

        // Lower edge of the eye, walking back through it from above
        st_dn_step:
        begin
          idly_q.ce  <= 1'b1;
          idly_q.inc <= 1'b0;
          settle_q   <= '0;
          state_q    <= st_dn_wait;
        end

        st_dn_wait:
        begin
          settle_q <= settle_q + 1'b1;
          if (settle_done)
          begin
            if (!found)
            begin
              sum_start_q <= sum_start_q + sum_w'(tap_i) + sum_w'(1);
              pass_q      <= pass_q + 1'b1;
              if (pass_q == pass_w'(xbus_align_pkg::num_passes - 1))
              begin
                state_q <= st_calc;
              end
              else
              begin
                state_q <= st_up_step;
              end
            end
            else if (tap_i == '0)
            begin
              status_q.error <= 1'b1;
              state_q        <= st_error;
            end
            else
            begin
              state_q <= st_dn_step;
            end
          end
        end

        // Averaged centre and width, both truncated
        st_calc:
        begin
          centre_q <= tap_w'(eye_total >> (xbus_align_pkg::avg_shift + 1));
          status_q.eye_size <= tap_w'(eye_diff >> xbus_align_pkg::avg_shift) + 1'b1;
          state_q  <= st_walk;
        end

        // One step per walk_gap cycles so that tap_i is current on return
        st_walk:
        begin
          if (tap_i == centre_q)
          begin
            status_q.aligned <= 1'b1;
            state_q          <= st_done;
          end
          else
          begin
            idly_q.ce  <= 1'b1;
            idly_q.inc <= (tap_i < centre_q);
            settle_q   <= '0;
            state_q    <= st_walk_gap;
          end
        end

        st_walk_gap:
        begin
          settle_q <= settle_q + 1'b1;
          if (gap_done)
          begin
            state_q <= st_walk;
          end
        end

        // Locked until the next reset
        st_done:
        begin
          state_q <= st_done;
        end

        // Failed training, held until the next reset
        st_error:
        begin
          state_q <= st_error;
        end

        default:
        begin
          state_q <= st_init;
        end
      endcase
    end
  end

  // ========================================
  // Word forwarding
  // ========================================

  // Once aligned, every input word leaves one cycle later
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      word_vld_q <= 1'b0;
    end
    else
    begin
      word_vld_q <= status_q.aligned;
    end
  end

  // The token compare is done here once, downstream only reads the flag
  always_ff @(posedge clk_i)
  begin
    word_q.data     <= dat_i;
    word_q.is_token <= tok_match;
  end

  assign idly_o     = idly_q;
  assign status_o   = status_q;
  assign word_o     = word_q;
  assign word_vld_o = word_vld_q;

endmodule

`default_nettype wire

// File: hw/xbus_rx_channel.sv
`timescale 1ns/1ns
`default_nettype none

// Receive side of one xbus lane
// The aligner trains the delay and feeds words straight to the packer,
// there is no back-pressure between them
module xbus_rx_channel #(
  parameter int p_token_run      = 3,
  parameter int p_settle_cycles  = 8,
  parameter int p_search_timeout = 64
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_i,
  input  wire logic [xbus_link_pkg::word_width-1:0] dat_i,
  input  wire logic [xbus_align_pkg::tap_width-1:0] tap_i,
  output xbus_align_pkg::idly_ctrl_t                idly_o,
  output xbus_align_pkg::align_status_t             status_o,
  output xbus_link_pkg::pair_t                      pair_o,
  output logic                                      pair_vld_o
);

  // Aligned word stream, one strobe per word
  xbus_link_pkg::rx_word_t word;
  logic                    word_vld;

  xbus_phase_align #(
    .p_token_run      (p_token_run),
    .p_settle_cycles  (p_settle_cycles),
    .p_search_timeout (p_search_timeout)
  ) u_phase_align (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .dat_i      (dat_i),
    .tap_i      (tap_i),
    .idly_o     (idly_o),
    .status_o   (status_o),
    .word_o     (word),
    .word_vld_o (word_vld)
  );

  xbus_word_pack u_word_pack (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .word_i     (word),
    .word_vld_i (word_vld),
    .pair_o     (pair_o),
    .pair_vld_o (pair_vld_o)
  );

endmodule

`default_nettype wire

// File: hw/xbus_word_pack.sv
`timescale 1ns/1ns
`default_nettype none

// Word packer
// Drops control tokens from the aligned word stream and joins each pair of
// data words into one wide word
module xbus_word_pack (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire xbus_link_pkg::rx_word_t word_i,
  input  wire logic                    word_vld_i,
  output xbus_link_pkg::pair_t         pair_o,
  output logic                         pair_vld_o
);

  logic                   data_vld;
  logic                   half_q;
  xbus_link_pkg::pair_t   pair_q;
  logic                   pair_vld_q;

  // Tokens are strobed like data words but carry no payload
  assign data_vld = word_vld_i && !word_i.is_token;

  // ========================================
  // Pair control
  // ========================================

  // half_q marks that the low half already holds the first word of a pair
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      half_q     <= 1'b0;
      pair_vld_q <= 1'b0;
    end
    else
    begin
      pair_vld_q <= 1'b0;
      if (data_vld)
      begin
        if (half_q)
        begin
          // Second word completes the pair, strobe it out
          pair_vld_q <= 1'b1;
          half_q     <= 1'b0;
        end
        else
        begin
          half_q <= 1'b1;
        end
      end
    end
  end

  // ========================================
  // Pair payload
  // ========================================

  // The low half is refilled by the next first word, so pair_o is only
  // meaningful while the strobe is high
  always_ff @(posedge clk_i)
  begin
    if (data_vld)
    begin
      if (half_q)
      begin
        pair_q.hi <= word_i.data;
      end
      else
      begin
        pair_q.lo <= word_i.data;
      end
    end
  end

  assign pair_o     = pair_q;
  assign pair_vld_o = pair_vld_q;

endmodule

`default_nettype wire
